// File: Makefile
# Verilator build and run for the LED matrix command path.
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = led_matrix_tb
FILELIST = led_matrix_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

# the log decides the result, the simulator exit status is not used.
run: compile
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported an error"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/led_matrix_assert.sv
`timescale 1ns/1ps
/* LED matrix bound checks. APB response rules and loader write timing. */
module led_matrix_assert (
    input logic                     clk,
    input logic                     reset,
    input led_matrix_pkg::apb_req_t apb,
    input logic                     pready,
    input logic                     pslverr,
    input logic                     byte_valid,
    input logic                     wr_en,
    input logic                     frame_done,
    input logic                     busy
);
    wr_follows_byte: assert property (@(posedge clk) disable iff (reset)
        wr_en == $past(byte_valid))
        else $error("loader write strobe did not follow the data byte by one cycle");

    no_slave_error: assert property (@(posedge clk) disable iff (reset) !pslverr)
        else $error("pslverr was raised");

    // only the first access cycle of a RAM readback waits.
    wait_only_on_readback: assert property (@(posedge clk) disable iff (reset)
        !pready |-> apb.psel && apb.penable && !apb.pwrite &&
                    apb.paddr == led_matrix_pkg::reg_read_data)
        else $error("pready low outside a read data access");

    // a RAM readback waits exactly one access cycle.
    readback_waits_once: assert property (@(posedge clk) disable iff (reset)
        apb.psel && apb.penable && !apb.pwrite &&
        apb.paddr == led_matrix_pkg::reg_read_data |-> pready == $past(apb.penable))
        else $error("read data access did not have exactly one wait state");

    done_only_when_busy: assert property (@(posedge clk) disable iff (reset)
        frame_done |-> busy)
        else $error("frame_done while the dispatcher was idle");

endmodule

bind led_matrix_top led_matrix_assert u_assert (
    .clk        (clk),
    .reset      (reset),
    .apb        (apb),
    .pready     (pready),
    .pslverr    (pslverr),
    .byte_valid (byte_valid),
    .wr_en      (wr_en),
    .frame_done (frame_done),
    .busy       (u_decoder.state)
);

// File: dv/led_matrix_stimulus.txt
# op reg data expect, all hex. w writes data to reg, r checks (read & data) == expect,
# f sends opcode data then one random frame and checks the whole frame readback.
r 4 ff 00
r 0 ff 00
r 8 ff 00
f 0 01 00
r 4 01 00
r 4 0e 02
r 4 f0 00
w 0 02 00
r 4 01 01
w 0 5a 00
r 0 ff 5a
r 4 01 00
w 0 07 00
r 4 f0 10
r 4 01 00
w 0 02 00
w 0 33 00
r 0 ff 33
r 4 ff 12
f 0 01 00
r 4 ff 14
r 0 ff 33
w 8 05 00
r 8 ff 05
w 8 5f 00
r 8 ff 5f
r 4 ff 14
r 4 01 00

// File: dv/led_matrix_tb.sv
`timescale 1ns/1ps
/* LED matrix command path testbench. Replays the stimulus file over APB
   and checks readback against a model of the reversed frame order. */
module led_matrix_tb;
    localparam int pixel_width = 8;
    localparam int pixel_height = 4;
    localparam int bytes_per_pixel = 3;
    localparam int frame_bytes = pixel_width * pixel_height * bytes_per_pixel;

    logic                     clk;
    logic                     reset;
    led_matrix_pkg::apb_req_t apb;
    logic [7:0]               prdata;
    logic                     pready;
    logic                     pslverr;

    logic [7:0]  st_op [$];
    logic [3:0]  st_reg [$];
    logic [7:0]  st_data [$];
    logic [7:0]  st_expect [$];
    logic [7:0]  model [frame_bytes];
    logic [31:0] lcg_state;
    int          cycles;
    int          cycle_limit;

    led_matrix_top #(
        .PIXEL_WIDTH     (pixel_width),
        .PIXEL_HEIGHT    (pixel_height),
        .BYTES_PER_PIXEL (bytes_per_pixel)
    ) u_dut (
        .clk     (clk),
        .reset   (reset),
        .apb     (apb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $fatal(1, "watchdog expired");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, expected);
            $display("test failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // starts and ends 2 ns after a rising edge.
    task automatic apb_transfer(input logic write, input logic [3:0] addr,
                                input logic [7:0] wdata, output logic [7:0] rdata);
        logic ready;
        apb.psel = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite = write;
        apb.paddr = addr;
        apb.pwdata = wdata;
        @(posedge clk);
        #2;
        apb.penable = 1'b1;
        do begin
            @(negedge clk);
            ready = pready;
            rdata = prdata;
            @(posedge clk);
            #2;
        end while (!ready);
        apb = '0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        apb_transfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [7:0] data);
        apb_transfer(1'b0, addr, 8'h00, data);
    endtask

    // first byte sent lands at the highest address.
    task automatic load_random_frame(input logic [7:0] opcode);
        logic [7:0] value;
        logic [7:0] got;
        int         n;
        apb_write(led_matrix_pkg::reg_data, opcode);
        for (n = 0; n < frame_bytes; n++) begin
            lcg_state = lcg_next(lcg_state);
            value = lcg_state[23:16];
            model[frame_bytes - 1 - n] = value;
            apb_write(led_matrix_pkg::reg_data, value);
            if (n == frame_bytes / 2) begin
                apb_read(led_matrix_pkg::reg_status, got);
                check_value("status busy bit", {7'd0, got[0]}, 8'h01);
            end
        end
        for (n = 0; n < frame_bytes; n++) begin
            apb_write(led_matrix_pkg::reg_read_addr, 8'(n));
            apb_read(led_matrix_pkg::reg_read_data, got);
            check_value($sformatf("prdata of frame byte %0d", n), got, model[n]);
        end
    endtask

    initial begin
        int         fd;
        int         fields;
        int         frames;
        int         i;
        string      line;
        logic [7:0] op;
        logic [7:0] rg;
        logic [7:0] data;
        logic [7:0] expected;
        logic [7:0] got;
        apb = '0;
        reset = 1'b1;
        cycles = 0;
        cycle_limit = 0;
        frames = 0;
        lcg_state = 32'ha360;
        fd = $fopen("dv/led_matrix_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file dv/led_matrix_stimulus.txt");
            $display("test failed");
            $fatal(1, "no stimulus");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%c %h %h %h", op, rg, data, expected);
                if (fields != 4) begin
                    $display("stimulus line could not be parsed: %s", line);
                    $display("test failed");
                    $fatal(1, "bad stimulus");
                end
                st_op.push_back(op);
                st_reg.push_back(rg[3:0]);
                st_data.push_back(data);
                st_expect.push_back(expected);
                if (op == "f") frames++;
            end
        end
        $fclose(fd);
        cycle_limit = 20 * (st_op.size() + frames * frame_bytes) + 200;

        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        for (i = 0; i < st_op.size(); i++) begin
            case (st_op[i])
                "w": apb_write(st_reg[i], st_data[i]);
                "r": begin
                    apb_read(st_reg[i], got);
                    check_value($sformatf("prdata of register %h masked %h", st_reg[i],
                                          st_data[i]), got & st_data[i], st_expect[i]);
                end
                "f": load_random_frame(st_data[i]);
                default: begin
                    $display("unknown operation letter in stimulus entry %0d", i);
                    $display("test failed");
                    $fatal(1, "bad stimulus");
                end
            endcase
        end
        $display("test passed");
        $finish;
    end

endmodule

// File: led_matrix_top.f
verilog/led_matrix_pkg.sv
verilog/matrix_cmd_decoder.sv
verilog/frame_loader.sv
verilog/frame_buffer.sv
verilog/led_matrix_top.sv
dv/led_matrix_assert.sv
dv/led_matrix_tb.sv

// File: verilog/frame_buffer.sv
`timescale 1ns/1ps
/* Frame buffer RAM with one write port by pixel address
   and one registered read port by linear address. */
module frame_buffer #(
    parameter int PIXEL_WIDTH = 8,
    parameter int PIXEL_HEIGHT = 4,
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic                                   clk,
    input  logic                                   wr_en,
    input  led_matrix_pkg::pixel_addr_t            wr_addr,
    input  logic [7:0]                             wr_data,
    input  logic [led_matrix_pkg::linear_bits-1:0] rd_addr,
    output logic [7:0]                             rd_data
);
    localparam int depth = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int row_stride = PIXEL_WIDTH * BYTES_PER_PIXEL;

    logic [7:0]                             mem [depth];
    logic [led_matrix_pkg::linear_bits-1:0] wr_lin;

    // row major, colors of a pixel adjacent.
    assign wr_lin = (led_matrix_pkg::linear_bits)'(wr_addr.row * row_stride +
                                                   wr_addr.column * BYTES_PER_PIXEL +
                                                   wr_addr.color);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_lin] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verilog/frame_loader.sv
`timescale 1ns/1ps
/* Frame loader. Walks row, column and color down from the last byte
   of the frame and writes each received byte into the frame buffer. */
module frame_loader #(
    parameter int PIXEL_WIDTH = 8,
    parameter int PIXEL_HEIGHT = 4,
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        byte_valid,
    input  logic [7:0]                  byte_data,
    output logic                        frame_done,
    output logic                        wr_en,
    output led_matrix_pkg::pixel_addr_t wr_addr,
    output logic [7:0]                  wr_data
);
    localparam logic [led_matrix_pkg::row_bits-1:0] last_row =
        (led_matrix_pkg::row_bits)'(PIXEL_HEIGHT - 1);
    localparam logic [led_matrix_pkg::column_bits-1:0] last_column =
        (led_matrix_pkg::column_bits)'(PIXEL_WIDTH - 1);
    localparam logic [led_matrix_pkg::color_bits-1:0] last_color =
        (led_matrix_pkg::color_bits)'(BYTES_PER_PIXEL - 1);

    led_matrix_pkg::pixel_addr_t pos;
    logic                        at_zero;

    assign at_zero = (pos == '0);
    assign frame_done = byte_valid & at_zero;

    always_ff @(posedge clk) begin
        if (reset) begin
            pos.row <= last_row;
            pos.column <= last_column;
            pos.color <= last_color;
            wr_en <= 1'b0;
        end else begin
            wr_en <= byte_valid;
            if (byte_valid) begin
                // color steps first, then column, then row.
                if (pos.color != '0) begin
                    pos.color <= pos.color - 1'b1;
                end else begin
                    pos.color <= last_color;
                    if (pos.column != '0) begin
                        pos.column <= pos.column - 1'b1;
                    end else begin
                        pos.column <= last_column;
                        // wraps back to the top after position zero.
                        if (pos.row != '0) begin
                            pos.row <= pos.row - 1'b1;
                        end else begin
                            pos.row <= last_row;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            wr_addr <= pos;
            wr_data <= byte_data;
        end
    end

endmodule

// File: verilog/led_matrix_pkg.sv
/* LED matrix controller shared definitions.
   Field widths, bus and address structs, register map and opcodes. */
package led_matrix_pkg;

    // widest frame the address fields can hold.
    localparam int row_bits = 4;
    localparam int column_bits = 5;
    localparam int color_bits = 2;

    // linear byte address into the frame buffer.
    localparam int linear_bits = 7;

    typedef struct packed {
        logic [row_bits-1:0]    row;
        logic [column_bits-1:0] column;
        logic [color_bits-1:0]  color;
    } pixel_addr_t;

    // host side of the APB transfer.
    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [3:0] paddr;
        logic [7:0] pwdata;
    } apb_req_t;

    localparam logic [3:0] reg_data = 4'h0;
    localparam logic [3:0] reg_status = 4'h4;
    localparam logic [3:0] reg_read_addr = 4'h8;
    localparam logic [3:0] reg_read_data = 4'hC;

    // first byte of every command.
    localparam logic [7:0] op_load_frame = 8'h01;
    localparam logic [7:0] op_set_brightness = 8'h02;

endpackage

// File: verilog/led_matrix_top.sv
`timescale 1ns/1ps
/* LED matrix command path. APB decoder, frame loader and frame buffer. */
module led_matrix_top #(
    parameter int PIXEL_WIDTH = 8,
    parameter int PIXEL_HEIGHT = 4,
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic                     clk,
    input  logic                     reset,
    input  led_matrix_pkg::apb_req_t apb,
    output logic [7:0]               prdata,
    output logic                     pready,
    output logic                     pslverr
);
    logic                                   byte_valid;
    logic [7:0]                             byte_data;
    logic                                   frame_done;
    logic                                   wr_en;
    led_matrix_pkg::pixel_addr_t            wr_addr;
    logic [7:0]                             wr_data;
    logic [led_matrix_pkg::linear_bits-1:0] rd_addr;
    logic [7:0]                             rd_data;

    matrix_cmd_decoder u_decoder (
        .clk        (clk),
        .reset      (reset),
        .apb        (apb),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .frame_done (frame_done),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    frame_loader #(
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HEIGHT    (PIXEL_HEIGHT),
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL)
    ) u_loader (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .frame_done (frame_done),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    frame_buffer #(
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HEIGHT    (PIXEL_HEIGHT),
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL)
    ) u_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: verilog/matrix_cmd_decoder.sv
`timescale 1ns/1ps
/* Matrix command decoder. APB register file plus an opcode dispatcher
   that feeds data bytes to the frame loader or the brightness register. */
module matrix_cmd_decoder (
    input  logic                                   clk,
    input  logic                                   reset,
    input  led_matrix_pkg::apb_req_t               apb,
    output logic [7:0]                             prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    output logic                                   byte_valid,
    output logic [7:0]                             byte_data,
    input  logic                                   frame_done,
    output logic [led_matrix_pkg::linear_bits-1:0] rd_addr,
    input  logic [7:0]                             rd_data
);
    typedef enum logic {
        st_idle,
        st_route
    } disp_state_t;

    disp_state_t state;
    logic        to_loader;
    logic [7:0]  brightness;
    logic [2:0]  frame_count;
    logic [3:0]  err_count;
    logic        rd_wait;
    logic        access;
    logic        data_write;
    logic        addr_write;
    logic        rd_data_access;

    assign access = apb.psel & apb.penable;
    assign data_write = access & apb.pwrite & (apb.paddr == led_matrix_pkg::reg_data);
    assign addr_write = access & apb.pwrite & (apb.paddr == led_matrix_pkg::reg_read_addr);
    assign rd_data_access = access & ~apb.pwrite &
                            (apb.paddr == led_matrix_pkg::reg_read_data);

    // first access cycle of a RAM readback is held off.
    assign pready = ~(rd_data_access & ~rd_wait);
    assign pslverr = 1'b0;

    always_comb begin
        case (apb.paddr)
            led_matrix_pkg::reg_data:      prdata = brightness;
            led_matrix_pkg::reg_status:    prdata = {err_count, frame_count, state == st_route};
            led_matrix_pkg::reg_read_addr: prdata = 8'(rd_addr);
            led_matrix_pkg::reg_read_data: prdata = rd_data;
            default:                       prdata = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            to_loader <= 1'b0;
            byte_valid <= 1'b0;
            brightness <= 8'h00;
            frame_count <= 3'd0;
            err_count <= 4'd0;
            rd_addr <= '0;
            rd_wait <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            rd_wait <= rd_data_access & ~rd_wait;
            if (addr_write) begin
                rd_addr <= apb.pwdata[led_matrix_pkg::linear_bits-1:0];
            end
            if (data_write) begin
                case (state)
                    st_idle: begin
                        // opcode byte.
                        if (apb.pwdata == led_matrix_pkg::op_load_frame) begin
                            state <= st_route;
                            to_loader <= 1'b1;
                        end else if (apb.pwdata == led_matrix_pkg::op_set_brightness) begin
                            state <= st_route;
                            to_loader <= 1'b0;
                        end else begin
                            err_count <= err_count + 4'd1;
                        end
                    end
                    st_route: begin
                        if (to_loader) begin
                            byte_valid <= 1'b1;
                        end else begin
                            brightness <= apb.pwdata;
                            state <= st_idle;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
            // loader took the last byte of the frame.
            if (frame_done) begin
                frame_count <= frame_count + 3'd1;
                state <= st_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_write) begin
            byte_data <= apb.pwdata;
        end
    end

endmodule
